// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal --timescale 1ns/100ps
TOP      = lsu_pipe_tb
FILELIST = lsu_pipe_top.f

.PHONY: simulate clean

simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep "ALL CHECKS PASSED" > /dev/null

clean:
	rm -rf obj_dir

// File: common/lsu_defs.svh
// Widths, memory size and read latency for the load/store pipeline
// DMEM_LATENCY must be 1 or more

`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// Register file and datapath
`define XLEN          64
`define RF_ADDR_WD    5
`define PC_WD         64

// Local data memory, byte addressed
`define DMEM_ADDR_WD  11
`define DMEM_DEPTH    256

// Cycles from request edge to rdata_valid
`define DMEM_LATENCY  2

`endif

// File: common/mem_access_pkg.sv
// Access size and extension encodings shared by the pipeline and the data memory

package mem_access_pkg;

    // Access width, log2 of the byte count
    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2,
        SIZE_D = 2'd3
    } mem_size_t;

    // How a narrow load is widened to XLEN
    typedef enum logic {
        EXT_ZERO = 1'b0,
        EXT_SIGN = 1'b1
    } ext_t;

endpackage

// File: common/pipe_pkg.sv
// Operation codes and stage payloads of the load/store pipeline

`include "lsu_defs.svh"

package pipe_pkg;

    import mem_access_pkg::*;

    typedef enum logic [1:0] {
        OP_ADDI  = 2'd0,
        OP_LOAD  = 2'd1,
        OP_STORE = 2'd2
    } op_t;

    // Execute to memory
    typedef struct packed {
        op_t                    op;
        logic [`RF_ADDR_WD-1:0] rd;
        logic                   we;
        mem_size_t              size;
        ext_t                   ext;
        logic [`XLEN-1:0]       result;   // ADDI sum, or aligned address
        logic [`PC_WD-1:0]      pc;
    } ex_to_mem_t;

    // Memory to writeback
    typedef struct packed {
        logic                   we;
        logic [`RF_ADDR_WD-1:0] rd;
        logic [`XLEN-1:0]       result;
        logic [`PC_WD-1:0]      pc;
    } mem_to_wb_t;

endpackage

// File: execute/execute_stage.sv
// Execute stage: operand bypass, load-use stall, address generation
// Memory request is raised only in the cycle the instruction moves on
`timescale 1ns/100ps

`include "lsu_defs.svh"

module execute_stage
    import mem_access_pkg::*;
    import pipe_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    // Issue port
    input  logic                   in_valid,
    input  op_t                    in_op,
    input  logic [`RF_ADDR_WD-1:0] in_rd,
    input  logic [`RF_ADDR_WD-1:0] in_rs1,
    input  logic [`RF_ADDR_WD-1:0] in_rs2,
    input  logic [`XLEN-1:0]       in_imm,
    input  mem_size_t              in_size,
    input  ext_t                   in_ext,
    input  logic [`PC_WD-1:0]      in_pc,
    output logic                   in_ready,
    // Register file read
    output logic [`RF_ADDR_WD-1:0] rf_rs1,
    output logic [`RF_ADDR_WD-1:0] rf_rs2,
    input  logic [`XLEN-1:0]       rf_rdata1,
    input  logic [`XLEN-1:0]       rf_rdata2,
    // Forwarding
    input  logic                   ms_fwd_we,
    input  logic                   ms_fwd_pending,
    input  logic [`RF_ADDR_WD-1:0] ms_fwd_rd,
    input  logic [`XLEN-1:0]       ms_fwd_data,
    input  logic                   ws_fwd_we,
    input  logic [`RF_ADDR_WD-1:0] ws_fwd_rd,
    input  logic [`XLEN-1:0]       ws_fwd_data,
    // To memory stage
    input  logic                   ms_allowin,
    output logic                   es_to_ms_valid,
    output ex_to_mem_t             es_to_ms,
    // Data memory request
    output logic                   req_valid,
    output logic                   req_write,
    output logic [`DMEM_ADDR_WD-1:0] req_addr,
    output logic [`XLEN-1:0]       req_wdata,
    output mem_size_t              req_size
);

    typedef struct packed {
        op_t                    op;
        logic [`RF_ADDR_WD-1:0] rd;
        logic [`RF_ADDR_WD-1:0] rs1;
        logic [`RF_ADDR_WD-1:0] rs2;
        logic [`XLEN-1:0]       imm;
        mem_size_t              size;
        ext_t                   ext;
        logic [`PC_WD-1:0]      pc;
    } issue_t;

    issue_t                   iss_d;
    issue_t                   iss;
    logic                     es_ready_go;
    logic                     ms_hit1, ms_hit2, ws_hit1, ws_hit2;
    logic                     is_store;
    logic [`XLEN-1:0]         src1, src2, sum;
    logic [`DMEM_ADDR_WD-1:0] addr_mask;
    logic [`DMEM_ADDR_WD-1:0] addr_aligned;

    assign iss_d = '{op: in_op, rd: in_rd, rs1: in_rs1, rs2: in_rs2, imm: in_imm,
                     size: in_size, ext: in_ext, pc: in_pc};

    pipe_reg #(.payload_t(issue_t)) es_reg (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_data      (iss_d),
        .ready_go     (es_ready_go),
        .next_allowin (ms_allowin),
        .allowin      (in_ready),
        .out_valid    (es_to_ms_valid),
        .data         (iss)
    );

    // ------------------------------------------------------------------------
    // Operand read and bypass
    // ------------------------------------------------------------------------
    assign rf_rs1   = iss.rs1;
    assign rf_rs2   = iss.rs2;
    assign is_store = (iss.op == OP_STORE);

    // x0 is never forwarded
    assign ms_hit1 = ms_fwd_we && (ms_fwd_rd == iss.rs1) && (iss.rs1 != '0);
    assign ms_hit2 = ms_fwd_we && (ms_fwd_rd == iss.rs2) && (iss.rs2 != '0);
    assign ws_hit1 = ws_fwd_we && (ws_fwd_rd == iss.rs1) && (iss.rs1 != '0);
    assign ws_hit2 = ws_fwd_we && (ws_fwd_rd == iss.rs2) && (iss.rs2 != '0);

    // Younger producer in memory wins over writeback
    assign src1 = ms_hit1 ? ms_fwd_data : (ws_hit1 ? ws_fwd_data : rf_rdata1);
    assign src2 = ms_hit2 ? ms_fwd_data : (ws_hit2 ? ws_fwd_data : rf_rdata2);

    // Load-use; rs2 only matters for stores
    assign es_ready_go = !(ms_fwd_pending && (ms_hit1 || (is_store && ms_hit2)));

    // ------------------------------------------------------------------------
    // Address generation and memory request
    // ------------------------------------------------------------------------
    assign sum          = src1 + iss.imm;
    assign addr_mask    = {`DMEM_ADDR_WD{1'b1}} << iss.size;
    assign addr_aligned = sum[`DMEM_ADDR_WD-1:0] & addr_mask;

    always_comb begin
        es_to_ms.op   = iss.op;
        es_to_ms.rd   = iss.rd;
        es_to_ms.we   = !is_store;
        es_to_ms.size = iss.size;
        es_to_ms.ext  = iss.ext;
        es_to_ms.pc   = iss.pc;
        if (iss.op == OP_ADDI) begin
            es_to_ms.result = sum;
        end else begin
            es_to_ms.result = {{(`XLEN-`DMEM_ADDR_WD){1'b0}}, addr_aligned};
        end
    end

    assign req_valid = es_to_ms_valid && ms_allowin && (iss.op != OP_ADDI);
    assign req_write = is_store;
    assign req_addr  = addr_aligned;
    assign req_wdata = src2;
    assign req_size  = iss.size;

endmodule

// File: lsu_pipe_top.f
+incdir+common
common/mem_access_pkg.sv
common/pipe_pkg.sv
verilog/pipe_reg.sv
execute/execute_stage.sv
memory/memory_stage.sv
memory/data_mem.sv
verilog/writeback_stage.sv
verilog/lsu_pipe_top.sv
verification/lsu_pipe_assertions.sv
verification/lsu_pipe_tb.sv

// File: memory/data_mem.sv
// 2 KiB data RAM, byte lanes from address and size, not cleared by reset
// Read data arrives DMEM_LATENCY cycles after the request, shifted to bit 0
`timescale 1ns/100ps

`include "lsu_defs.svh"

module data_mem
    import mem_access_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     req_valid,
    input  logic                     req_write,
    input  logic [`DMEM_ADDR_WD-1:0] req_addr,
    input  logic [`XLEN-1:0]         req_wdata,
    input  mem_size_t                req_size,
    output logic                     rdata_valid,
    output logic [`XLEN-1:0]         rdata
);

    localparam int LATENCY = `DMEM_LATENCY;
    localparam int DEPTH   = `DMEM_DEPTH;

    logic [`XLEN-1:0] mem [DEPTH];
    logic [7:0]       word_idx;
    logic [2:0]       byte_off;
    logic [7:0]       size_mask;
    logic [7:0]       byte_en;
    logic [`XLEN-1:0] wdata_lane;
    logic [LATENCY-1:0] valid_pipe;
    logic [`XLEN-1:0] data_pipe [LATENCY];

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    assign word_idx = req_addr[`DMEM_ADDR_WD-1:3];
    assign byte_off = req_addr[2:0];

    always_comb begin
        case (req_size)
            SIZE_B:  size_mask = 8'h01;
            SIZE_H:  size_mask = 8'h03;
            SIZE_W:  size_mask = 8'h0f;
            default: size_mask = 8'hff;
        endcase
    end

    assign byte_en    = size_mask << byte_off;
    assign wdata_lane = req_wdata << {byte_off, 3'b000};

    always_ff @(posedge clk) begin
        if (req_valid && req_write) begin
            for (int b = 0; b < 8; b++) begin
                if (byte_en[b]) begin
                    mem[word_idx][8*b +: 8] <= wdata_lane[8*b +: 8];
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Read delay line
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe[0] <= req_valid && !req_write;
            for (int i = 1; i < LATENCY; i++) begin
                valid_pipe[i] <= valid_pipe[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        data_pipe[0] <= mem[word_idx] >> {byte_off, 3'b000};
        for (int i = 1; i < LATENCY; i++) begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    assign rdata_valid = valid_pipe[LATENCY-1];
    assign rdata       = data_pipe[LATENCY-1];

endmodule

// File: memory/memory_stage.sv
// Memory stage: holds returned load data until writeback takes the instruction
// Assumes one outstanding load, issued as the load enters this stage
`timescale 1ns/100ps

`include "lsu_defs.svh"

module memory_stage
    import mem_access_pkg::*;
    import pipe_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   es_to_ms_valid,
    input  ex_to_mem_t             es_to_ms,
    output logic                   ms_allowin,
    input  logic                   rdata_valid,
    input  logic [`XLEN-1:0]       rdata,
    input  logic                   ws_allowin,
    output logic                   ms_to_ws_valid,
    output mem_to_wb_t             ms_to_ws,
    output logic                   ms_fwd_we,
    output logic                   ms_fwd_pending,
    output logic [`RF_ADDR_WD-1:0] ms_fwd_rd,
    output logic [`XLEN-1:0]       ms_fwd_data
);

    ex_to_mem_t       ms;
    logic             ms_ready_go;
    logic             is_load;
    logic             data_held;
    logic [`XLEN-1:0] held_data;
    logic [`XLEN-1:0] raw;
    logic [`XLEN-1:0] load_ext;
    logic             sgn;

    pipe_reg #(.payload_t(ex_to_mem_t)) ms_reg (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (es_to_ms_valid),
        .in_data      (es_to_ms),
        .ready_go     (ms_ready_go),
        .next_allowin (ws_allowin),
        .allowin      (ms_allowin),
        .out_valid    (ms_to_ws_valid),
        .data         (ms)
    );

    assign is_load     = (ms.op == OP_LOAD);
    assign ms_ready_go = !is_load || data_held || rdata_valid;

    // Load data stays here until the handoff to writeback
    always_ff @(posedge clk) begin
        if (reset) begin
            data_held <= 1'b0;
        end else if (ms_to_ws_valid && ws_allowin) begin
            data_held <= 1'b0;
        end else if (rdata_valid) begin
            data_held <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rdata_valid) begin
            held_data <= rdata;
        end
    end

    // ------------------------------------------------------------------------
    // Extension and result select
    // ------------------------------------------------------------------------
    assign raw = data_held ? held_data : rdata;
    assign sgn = (ms.ext == EXT_SIGN);

    always_comb begin
        case (ms.size)
            SIZE_B:  load_ext = {{(`XLEN-8){sgn & raw[7]}}, raw[7:0]};
            SIZE_H:  load_ext = {{(`XLEN-16){sgn & raw[15]}}, raw[15:0]};
            SIZE_W:  load_ext = {{(`XLEN-32){sgn & raw[31]}}, raw[31:0]};
            default: load_ext = raw;
        endcase
    end

    assign ms_to_ws.we     = ms.we;
    assign ms_to_ws.rd     = ms.rd;
    assign ms_to_ws.result = is_load ? load_ext : ms.result;
    assign ms_to_ws.pc     = ms.pc;

    // With ready_go low, allowin low means the stage is occupied
    assign ms_fwd_pending = is_load && !ms_ready_go && !ms_allowin;
    assign ms_fwd_we      = ms.we && (ms_to_ws_valid || ms_fwd_pending);
    assign ms_fwd_rd      = ms.rd;
    assign ms_fwd_data    = ms_to_ws.result;

endmodule

// File: verification/lsu_pipe_assertions.sv
// Handshake properties on the pipeline top, attached with bind
`timescale 1ns/100ps

`include "lsu_defs.svh"

module lsu_pipe_assertions (
    input logic                   clk,
    input logic                   reset,
    input logic                   in_ready,
    input logic                   commit_valid,
    input logic                   commit_ready,
    input logic                   commit_we,
    input logic [`RF_ADDR_WD-1:0] commit_rd,
    input logic [`XLEN-1:0]       commit_data,
    input logic [`PC_WD-1:0]      commit_pc
);

    // Number of property failures so far
    int failures = 0;

    // A stalled commit keeps its payload until it is taken
    commit_hold: assert property (@(posedge clk) disable iff (reset)
        commit_valid && !commit_ready |=>
            commit_valid && $stable({commit_we, commit_rd, commit_data, commit_pc}))
        else begin
            failures++;
            $error("commit outputs changed while commit_ready was low");
        end

    // Any cycle after a reset edge has no commit
    commit_quiet: assert property (@(posedge clk) $past(reset) |-> !commit_valid)
        else begin
            failures++;
            $error("commit_valid high during reset");
        end

    issue_open: assert property (@(posedge clk) $fell(reset) |-> in_ready)
        else begin
            failures++;
            $error("in_ready low in the first cycle after reset");
        end

endmodule

bind lsu_pipe_top lsu_pipe_assertions assert_i (
    .clk          (clk),
    .reset        (reset),
    .in_ready     (in_ready),
    .commit_valid (commit_valid),
    .commit_ready (commit_ready),
    .commit_we    (commit_we),
    .commit_rd    (commit_rd),
    .commit_data  (commit_data),
    .commit_pc    (commit_pc)
);

// File: verification/lsu_pipe_tb.sv
// Directed and random traffic checked against an in-order reference model
// Inputs change 0.5 ns after the rising edge, outputs are sampled at the falling edge
`timescale 1ns/100ps

`include "lsu_defs.svh"

module lsu_pipe_tb
    import mem_access_pkg::*;
    import pipe_pkg::*;
();

    localparam int CHAIN_LEN    = 40;
    localparam int LOAD_USE_LEN = 8;
    localparam int RANDOM_LEN   = 400;
    localparam int TOTAL_INSTR  = CHAIN_LEN + 27 + 3 * LOAD_USE_LEN + RANDOM_LEN;
    localparam int WATCHDOG_CYCLES = TOTAL_INSTR * (6 + `DMEM_LATENCY) * 8;

    typedef struct {
        logic                   we;
        logic [`RF_ADDR_WD-1:0] rd;
        logic [`XLEN-1:0]       data;
        logic [`PC_WD-1:0]      pc;
    } commit_t;

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   in_valid;
    op_t                    in_op;
    logic [`RF_ADDR_WD-1:0] in_rd, in_rs1, in_rs2;
    logic [`XLEN-1:0]       in_imm;
    mem_size_t              in_size;
    ext_t                   in_ext;
    logic [`PC_WD-1:0]      in_pc;
    logic                   in_ready;
    logic                   commit_valid, commit_we, commit_ready;
    logic [`RF_ADDR_WD-1:0] commit_rd;
    logic [`XLEN-1:0]       commit_data;
    logic [`PC_WD-1:0]      commit_pc;

    // Reference model state
    logic [`XLEN-1:0] model_rf [32];
    logic [7:0]       model_mem [2048];
    commit_t          exp_q [$];

    logic [31:0]       rng_state = 32'h3b65_c0a0;
    logic              backpressure = 1'b0;
    logic [`PC_WD-1:0] pc_next = 64'h1000;
    string             test_name = "init";
    int                checks = 0;
    int                errors = 0;
    int                test_first_error = 0;
    int                issued_cnt = 0;
    int                commit_cnt = 0;

    lsu_pipe_top dut_i (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [63:0] random64();
        logic [31:0] hi;
        hi = next_random();
        return {hi, next_random()};
    endfunction

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Error %s %s: expected %h, actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic start_test(input string name);
        test_name        = name;
        test_first_error = errors;
    endtask

    task automatic end_test();
        $display("Test %s finished with %0d errors", test_name, errors - test_first_error);
    endtask

    // Step to the next drive point and pick this cycle's commit_ready
    task automatic next_cycle();
        logic [31:0] r;
        @(posedge clk);
        #0.5;
        r = next_random();
        commit_ready = backpressure ? r[0] : 1'b1;
    endtask

    // ------------------------------------------------------------------------
    // Reference model, run in order as each instruction is accepted
    // ------------------------------------------------------------------------
    task automatic model_execute(input op_t op, input logic [4:0] rd, rs1, rs2,
                                 input logic [63:0] imm, input mem_size_t size,
                                 input ext_t ext, input logic [63:0] pc);
        commit_t     exp;
        logic [63:0] sum;
        logic [63:0] val;
        logic [10:0] addr;
        int          nbytes;
        int          i;
        nbytes = 1 << size;
        sum    = model_rf[rs1] + imm;
        addr   = sum[10:0] & ~11'(nbytes - 1);
        val    = '0;
        exp.we = (op != OP_STORE);
        if (op == OP_ADDI) begin
            val = sum;
        end else if (op == OP_LOAD) begin
            for (i = 0; i < nbytes; i++) begin
                val[8*i +: 8] = model_mem[int'(addr) + i];
            end
            if (ext == EXT_SIGN && nbytes < 8 && val[8*nbytes-1]) begin
                val = val | (~64'h0 << (8 * nbytes));
            end
        end else begin
            for (i = 0; i < nbytes; i++) begin
                model_mem[int'(addr) + i] = model_rf[rs2][8*i +: 8];
            end
            val = {53'b0, addr};
        end
        if (exp.we && rd != 0) begin
            model_rf[rd] = val;
        end
        exp.rd   = rd;
        exp.data = val;
        exp.pc   = pc;
        exp_q.push_back(exp);
    endtask

    // Hold the instruction on the issue port until the pipeline takes it
    task automatic issue_instr(input op_t op, input logic [4:0] rd, rs1, rs2,
                               input logic [63:0] imm, input mem_size_t size,
                               input ext_t ext);
        logic accepted;
        accepted = 1'b0;
        in_valid = 1'b1;
        in_op    = op;
        in_rd    = rd;
        in_rs1   = rs1;
        in_rs2   = rs2;
        in_imm   = imm;
        in_size  = size;
        in_ext   = ext;
        in_pc    = pc_next;
        while (!accepted) begin
            @(negedge clk);
            if (in_ready) begin
                accepted = 1'b1;
                model_execute(op, rd, rs1, rs2, imm, size, ext, pc_next);
                issued_cnt++;
            end
            next_cycle();
        end
        in_valid = 1'b0;
        pc_next  = pc_next + 4;
    endtask

    task automatic drain_commits();
        while (exp_q.size() != 0) begin
            next_cycle();
        end
        repeat (3) next_cycle();
    endtask

    // Commit monitor
    always @(negedge clk) begin
        commit_t exp;
        if (!reset && commit_valid && commit_ready) begin
            commit_cnt++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("Error %s: commit at pc %h with no instruction outstanding",
                         test_name, commit_pc);
            end else begin
                exp = exp_q.pop_front();
                check_value("commit_we", 64'(exp.we), 64'(commit_we));
                check_value("commit_rd", 64'(exp.rd), 64'(commit_rd));
                check_value("commit_data", exp.data, commit_data);
                check_value("commit_pc", exp.pc, commit_pc);
            end
        end
    end

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------
    task automatic run_reset_test();
        start_test("reset");
        repeat (5) @(posedge clk);
        #0.5;
        reset = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_value("in_ready", 64'd1, 64'(in_ready));
            check_value("commit_valid", 64'd0, 64'(commit_valid));
            next_cycle();
        end
        end_test();
    endtask

    task automatic run_addi_chains();
        logic [4:0] prev, prev2, rd, src;
        start_test("addi_chains");
        prev  = 5'd0;
        prev2 = 5'd0;
        for (int n = 0; n < CHAIN_LEN; n++) begin
            rd  = 5'(n % 7 + 1);
            // Every third one reaches back two instructions
            src = (n % 3 == 2) ? prev2 : prev;
            issue_instr(OP_ADDI, rd, src, 5'd0, random64(), SIZE_D, EXT_ZERO);
            prev2 = prev;
            prev  = rd;
        end
        drain_commits();
        end_test();
    endtask

    task automatic run_store_load();
        logic [63:0] data;
        logic [63:0] off;
        mem_size_t   size;
        start_test("store_load");
        issue_instr(OP_ADDI, 5'd6, 5'd0, 5'd0, 64'h100, SIZE_D, EXT_ZERO);
        for (int round = 0; round < 2; round++) begin
            // Byte sign bits all clear, then all set
            data = random64();
            data = (round == 0) ? (data & 64'h7f7f_7f7f_7f7f_7f7f)
                                : (data | 64'h8080_8080_8080_8080);
            issue_instr(OP_ADDI, 5'd5, 5'd0, 5'd0, data, SIZE_D, EXT_ZERO);
            for (int s = 0; s < 4; s++) begin
                size = mem_size_t'(s);
                off  = 64'(next_random() % 64);
                issue_instr(OP_STORE, 5'd0, 5'd6, 5'd5, off, size, EXT_ZERO);
                issue_instr(OP_LOAD, 5'd7, 5'd6, 5'd0, off, size, EXT_ZERO);
                issue_instr(OP_LOAD, 5'd8, 5'd6, 5'd0, off, size, EXT_SIGN);
            end
        end
        drain_commits();
        end_test();
    endtask

    task automatic run_load_use();
        logic [63:0] off;
        mem_size_t   size;
        start_test("load_use");
        for (int n = 0; n < LOAD_USE_LEN; n++) begin
            off  = 64'(next_random() % 64);
            size = mem_size_t'(next_random() % 4);
            issue_instr(OP_LOAD, 5'd9, 5'd6, 5'd0, off, size, ext_t'(n % 2));
            if (n % 2 == 0) begin
                issue_instr(OP_ADDI, 5'd10, 5'd9, 5'd0, random64(), SIZE_D, EXT_ZERO);
                issue_instr(OP_STORE, 5'd0, 5'd6, 5'd9, off + 64, SIZE_D, EXT_ZERO);
            end else begin
                issue_instr(OP_STORE, 5'd0, 5'd6, 5'd9, off + 64, SIZE_D, EXT_ZERO);
                issue_instr(OP_ADDI, 5'd10, 5'd9, 5'd0, random64(), SIZE_D, EXT_ZERO);
            end
        end
        drain_commits();
        end_test();
    endtask

    task automatic run_random_mix();
        logic [31:0] r;
        logic [4:0]  rs1;
        logic [63:0] imm;
        op_t         op;
        int          gap;
        start_test("random_mix");
        backpressure = 1'b1;
        for (int n = 0; n < RANDOM_LEN; n++) begin
            r   = next_random();
            op  = op_t'(2'(r % 3));
            rs1 = {2'b00, r[10:8]};
            imm = random64();
            // Half the memory ops go near address 0 so loads see stored data
            if (op != OP_ADDI && r[17]) begin
                rs1 = 5'd0;
                imm = 64'(next_random() % 128);
            end
            issue_instr(op, {2'b00, r[7:5]}, rs1, {2'b00, r[13:11]}, imm,
                        mem_size_t'(r[15:14]), ext_t'(r[16]));
            gap = int'(next_random() % 3);
            repeat (gap) next_cycle();
        end
        backpressure = 1'b0;
        drain_commits();
        check_value("commit count", 64'(issued_cnt), 64'(commit_cnt));
        end_test();
    endtask

    initial begin
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_op        = OP_ADDI;
        in_rd        = '0;
        in_rs1       = '0;
        in_rs2       = '0;
        in_imm       = '0;
        in_size      = SIZE_B;
        in_ext       = EXT_ZERO;
        in_pc        = '0;
        commit_ready = 1'b1;
        for (int i = 0; i < 32; i++) begin
            model_rf[i] = '0;
        end
        for (int i = 0; i < 2048; i++) begin
            model_mem[i] = 8'h00;
        end
        run_reset_test();
        run_addi_chains();
        run_store_load();
        run_load_use();
        run_random_mix();
        errors = errors + dut_i.assert_i.failures;
        $display("Summary: %0d checks, %0d errors, %0d instructions committed",
                 checks, errors, commit_cnt);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: verilog/lsu_pipe_top.sv
// Load/store pipeline top: execute, memory and writeback stages with local RAM
// in_ready is the execute stage allowin
`timescale 1ns/100ps

`include "lsu_defs.svh"

module lsu_pipe_top
    import mem_access_pkg::*;
    import pipe_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_valid,
    input  op_t                    in_op,
    input  logic [`RF_ADDR_WD-1:0] in_rd,
    input  logic [`RF_ADDR_WD-1:0] in_rs1,
    input  logic [`RF_ADDR_WD-1:0] in_rs2,
    input  logic [`XLEN-1:0]       in_imm,
    input  mem_size_t              in_size,
    input  ext_t                   in_ext,
    input  logic [`PC_WD-1:0]      in_pc,
    output logic                   in_ready,
    output logic                   commit_valid,
    output logic                   commit_we,
    output logic [`RF_ADDR_WD-1:0] commit_rd,
    output logic [`XLEN-1:0]       commit_data,
    output logic [`PC_WD-1:0]      commit_pc,
    input  logic                   commit_ready
);

    logic [`RF_ADDR_WD-1:0]   rf_rs1, rf_rs2;
    logic [`XLEN-1:0]         rf_rdata1, rf_rdata2;
    logic                     ms_fwd_we, ms_fwd_pending, ws_fwd_we;
    logic [`RF_ADDR_WD-1:0]   ms_fwd_rd, ws_fwd_rd;
    logic [`XLEN-1:0]         ms_fwd_data, ws_fwd_data;
    logic                     ms_allowin, ws_allowin;
    logic                     es_to_ms_valid, ms_to_ws_valid;
    ex_to_mem_t               es_to_ms;
    mem_to_wb_t               ms_to_ws;
    logic                     req_valid, req_write, rdata_valid;
    logic [`DMEM_ADDR_WD-1:0] req_addr;
    logic [`XLEN-1:0]         req_wdata, rdata;
    mem_size_t                req_size;

    execute_stage es_i (
        .clk, .reset,
        .in_valid, .in_op, .in_rd, .in_rs1, .in_rs2, .in_imm, .in_size, .in_ext, .in_pc,
        .in_ready,
        .rf_rs1, .rf_rs2, .rf_rdata1, .rf_rdata2,
        .ms_fwd_we, .ms_fwd_pending, .ms_fwd_rd, .ms_fwd_data,
        .ws_fwd_we, .ws_fwd_rd, .ws_fwd_data,
        .ms_allowin, .es_to_ms_valid, .es_to_ms,
        .req_valid, .req_write, .req_addr, .req_wdata, .req_size
    );

    memory_stage ms_i (
        .clk, .reset,
        .es_to_ms_valid, .es_to_ms, .ms_allowin,
        .rdata_valid, .rdata,
        .ws_allowin, .ms_to_ws_valid, .ms_to_ws,
        .ms_fwd_we, .ms_fwd_pending, .ms_fwd_rd, .ms_fwd_data
    );

    data_mem dmem_i (
        .clk, .reset,
        .req_valid, .req_write, .req_addr, .req_wdata, .req_size,
        .rdata_valid, .rdata
    );

    writeback_stage ws_i (
        .clk, .reset,
        .ms_to_ws_valid, .ms_to_ws, .ws_allowin,
        .commit_ready, .commit_valid, .commit_we, .commit_rd, .commit_data, .commit_pc,
        .rf_rs1, .rf_rs2, .rf_rdata1, .rf_rdata2,
        .ws_fwd_we, .ws_fwd_rd, .ws_fwd_data
    );

endmodule

// File: verilog/pipe_reg.sv
// Stage register with valid/allowin handshake
// Payload has no reset and only changes on an accepted transfer
`timescale 1ns/100ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    input  payload_t in_data,
    input  logic     ready_go,
    input  logic     next_allowin,
    output logic     allowin,
    output logic     out_valid,
    output payload_t data
);

    logic valid;

    // Empty, or finishing and the next stage takes it
    assign allowin   = !valid || (ready_go && next_allowin);
    assign out_valid = valid && ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (allowin) begin
            valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && allowin) begin
            data <= in_data;
        end
    end

endmodule

// File: verilog/writeback_stage.sv
// Writeback stage: commit handshake and the 32 x 64 register file
// The register file is written on the commit edge, x0 reads zero
`timescale 1ns/100ps

`include "lsu_defs.svh"

module writeback_stage
    import pipe_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   ms_to_ws_valid,
    input  mem_to_wb_t             ms_to_ws,
    output logic                   ws_allowin,
    input  logic                   commit_ready,
    output logic                   commit_valid,
    output logic                   commit_we,
    output logic [`RF_ADDR_WD-1:0] commit_rd,
    output logic [`XLEN-1:0]       commit_data,
    output logic [`PC_WD-1:0]      commit_pc,
    input  logic [`RF_ADDR_WD-1:0] rf_rs1,
    input  logic [`RF_ADDR_WD-1:0] rf_rs2,
    output logic [`XLEN-1:0]       rf_rdata1,
    output logic [`XLEN-1:0]       rf_rdata2,
    output logic                   ws_fwd_we,
    output logic [`RF_ADDR_WD-1:0] ws_fwd_rd,
    output logic [`XLEN-1:0]       ws_fwd_data
);

    mem_to_wb_t       ws;
    logic [`XLEN-1:0] rf [32];

    // Commit port acts as the next stage, so commit_valid never waits on commit_ready
    pipe_reg #(.payload_t(mem_to_wb_t)) ws_reg (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (ms_to_ws_valid),
        .in_data      (ms_to_ws),
        .ready_go     (1'b1),
        .next_allowin (commit_ready),
        .allowin      (ws_allowin),
        .out_valid    (commit_valid),
        .data         (ws)
    );

    assign commit_we   = ws.we;
    assign commit_rd   = ws.rd;
    assign commit_data = ws.result;
    assign commit_pc   = ws.pc;

    initial begin
        for (int i = 0; i < 32; i++) begin
            rf[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (commit_valid && commit_ready && ws.we && (ws.rd != '0)) begin
            rf[ws.rd] <= ws.result;
        end
    end

    assign rf_rdata1 = (rf_rs1 == '0) ? '0 : rf[rf_rs1];
    assign rf_rdata2 = (rf_rs2 == '0) ? '0 : rf[rf_rs2];

    // Result waiting on commit_ready is not yet in the register file
    assign ws_fwd_we   = commit_valid && ws.we;
    assign ws_fwd_rd   = ws.rd;
    assign ws_fwd_data = ws.result;

endmodule
